/* hw/fsctl_cfg.svh */
`ifndef FSCTL_CFG_SVH
`define FSCTL_CFG_SVH

// register bus
`define FSCTL_DATA_WIDTH     32
`define FSCTL_REG_IDX_WIDTH  8

// image coordinate widths
`define FSCTL_IMG_WBITS      12
`define FSCTL_IMG_HBITS      12

// y field position inside a geometry word, x sits at bit 0
`define FSCTL_IMG_H_LSB      16

// frame-buffer index
`define FSCTL_BUF_IDX_WIDTH  2

// bit distance between stream 0 and stream 1 fields in shared registers
`define FSCTL_INT_STRIDE     4

// read-only version word
`define FSCTL_CORE_VERSION   32'hFF00FF00

`endif

/* hw/fsctl_pkg.sv */
`include "fsctl_cfg.svh"

package fsctl_pkg;

	typedef logic [`FSCTL_DATA_WIDTH-1:0]    reg_data_t;
	typedef logic [`FSCTL_REG_IDX_WIDTH-1:0] reg_idx_t;
	typedef logic [`FSCTL_IMG_WBITS-1:0]     img_w_t;
	typedef logic [`FSCTL_IMG_HBITS-1:0]     img_h_t;
	typedef logic [`FSCTL_BUF_IDX_WIDTH-1:0] buf_idx_t;
	typedef logic [1:0]                      dst_bmp_t;

	// register map
	typedef enum logic [`FSCTL_REG_IDX_WIDTH-1:0] {
		REG_CTRL      = 0,
		REG_DST_BMP   = 1,
		REG_INT_EN    = 2,
		REG_INT_STATE = 3,
		REG_BUF_IDX   = 4,
		REG_S0_BASE   = 5,
		REG_S1_BASE   = 10,
		REG_VERSION   = 255
	} reg_addr_e;

	// geometry words, relative to a stream base
	typedef enum logic [2:0] {
		GEOM_SIZE     = 0,
		GEOM_WIN_POS  = 1,
		GEOM_WIN_SIZE = 2,
		GEOM_DST_POS  = 3,
		GEOM_DST_SIZE = 4
	} geom_off_e;

endpackage

/* hw/ctl_regs.sv */
`timescale 1ns/1ps
`include "fsctl_cfg.svh"

module ctl_regs (
	input  logic                 o_clk,
	input  logic                 o_resetn,
	input  logic                 i_wr_en,
	input  fsctl_pkg::reg_idx_t  i_wr_addr,
	input  fsctl_pkg::reg_data_t i_wr_data,
	input  logic                 i_rd_en,
	input  fsctl_pkg::reg_idx_t  i_rd_addr,
	output fsctl_pkg::reg_data_t o_rd_data,
	input  logic [1:0]           i_int_state,
	input  fsctl_pkg::buf_idx_t  i_s0_rd_buf_idx,
	input  fsctl_pkg::buf_idx_t  i_s1_rd_buf_idx,
	output logic                 o_soft_resetn,
	output logic                 o_cfg_hold,
	output logic [1:0]           o_int_en,
	output logic [1:0]           o_int_clr,
	output fsctl_pkg::dst_bmp_t  o_s0_dst_bmp,
	output fsctl_pkg::dst_bmp_t  o_s1_dst_bmp,
	output fsctl_pkg::img_w_t    o_s0_width, o_s0_win_left, o_s0_win_width,
	output fsctl_pkg::img_w_t    o_s0_dst_left, o_s0_dst_width,
	output fsctl_pkg::img_h_t    o_s0_height, o_s0_win_top, o_s0_win_height,
	output fsctl_pkg::img_h_t    o_s0_dst_top, o_s0_dst_height,
	output fsctl_pkg::img_w_t    o_s1_width, o_s1_win_left, o_s1_win_width,
	output fsctl_pkg::img_w_t    o_s1_dst_left, o_s1_dst_width,
	output fsctl_pkg::img_h_t    o_s1_height, o_s1_win_top, o_s1_win_height,
	output fsctl_pkg::img_h_t    o_s1_dst_top, o_s1_dst_height
);

	localparam int STRIDE   = `FSCTL_INT_STRIDE;
	localparam int H_LSB    = `FSCTL_IMG_H_LSB;
	localparam int WBITS    = $bits(fsctl_pkg::img_w_t);
	localparam int HBITS    = $bits(fsctl_pkg::img_h_t);
	localparam int BMP_BITS = $bits(fsctl_pkg::dst_bmp_t);
	localparam int BUF_BITS = $bits(fsctl_pkg::buf_idx_t);

	// stream 1 words follow stream 0 directly, one slot index covers both
	localparam int S0         = 0;
	localparam int S1         = fsctl_pkg::REG_S1_BASE - fsctl_pkg::REG_S0_BASE;
	localparam int GEOM_WORDS = 2 * S1;

	fsctl_pkg::img_w_t    geom_w [GEOM_WORDS];
	fsctl_pkg::img_h_t    geom_h [GEOM_WORDS];
	fsctl_pkg::reg_idx_t  wr_slot;
	fsctl_pkg::reg_idx_t  rd_slot;
	fsctl_pkg::reg_data_t rd_word;

	assign wr_slot = i_wr_addr - fsctl_pkg::REG_S0_BASE;
	assign rd_slot = i_rd_addr - fsctl_pkg::REG_S0_BASE;

	// --------------------------------------------------
	// write decode
	// --------------------------------------------------
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_soft_resetn <= 1'b0;
			o_cfg_hold    <= 1'b0;
			o_int_en      <= '0;
			o_s0_dst_bmp  <= '0;
			o_s1_dst_bmp  <= '0;
			for (int i = 0; i < GEOM_WORDS; i++) begin
				geom_w[i] <= '0;
				geom_h[i] <= '0;
			end
		end else if (i_wr_en) begin
			case (i_wr_addr)
				fsctl_pkg::REG_CTRL: begin
					o_soft_resetn <= i_wr_data[0];
					o_cfg_hold    <= i_wr_data[1];
				end
				fsctl_pkg::REG_DST_BMP: begin
					o_s0_dst_bmp <= i_wr_data[BMP_BITS-1:0];
					o_s1_dst_bmp <= i_wr_data[STRIDE +: BMP_BITS];
				end
				fsctl_pkg::REG_INT_EN: begin
					o_int_en <= {i_wr_data[STRIDE], i_wr_data[0]};
				end
				default: begin
					if (wr_slot < GEOM_WORDS) begin
						geom_w[wr_slot[3:0]] <= i_wr_data[WBITS-1:0];
						geom_h[wr_slot[3:0]] <= i_wr_data[H_LSB +: HBITS];
					end
				end
			endcase
		end
	end

	// write-one-to-clear, acts on the write edge itself
	assign o_int_clr = (i_wr_en && i_wr_addr == fsctl_pkg::REG_INT_STATE) ?
		{i_wr_data[STRIDE], i_wr_data[0]} : 2'b00;

	// shadow geometry towards the streams
	assign o_s0_width      = geom_w[S0 + fsctl_pkg::GEOM_SIZE];
	assign o_s0_height     = geom_h[S0 + fsctl_pkg::GEOM_SIZE];
	assign o_s0_win_left   = geom_w[S0 + fsctl_pkg::GEOM_WIN_POS];
	assign o_s0_win_top    = geom_h[S0 + fsctl_pkg::GEOM_WIN_POS];
	assign o_s0_win_width  = geom_w[S0 + fsctl_pkg::GEOM_WIN_SIZE];
	assign o_s0_win_height = geom_h[S0 + fsctl_pkg::GEOM_WIN_SIZE];
	assign o_s0_dst_left   = geom_w[S0 + fsctl_pkg::GEOM_DST_POS];
	assign o_s0_dst_top    = geom_h[S0 + fsctl_pkg::GEOM_DST_POS];
	assign o_s0_dst_width  = geom_w[S0 + fsctl_pkg::GEOM_DST_SIZE];
	assign o_s0_dst_height = geom_h[S0 + fsctl_pkg::GEOM_DST_SIZE];

	assign o_s1_width      = geom_w[S1 + fsctl_pkg::GEOM_SIZE];
	assign o_s1_height     = geom_h[S1 + fsctl_pkg::GEOM_SIZE];
	assign o_s1_win_left   = geom_w[S1 + fsctl_pkg::GEOM_WIN_POS];
	assign o_s1_win_top    = geom_h[S1 + fsctl_pkg::GEOM_WIN_POS];
	assign o_s1_win_width  = geom_w[S1 + fsctl_pkg::GEOM_WIN_SIZE];
	assign o_s1_win_height = geom_h[S1 + fsctl_pkg::GEOM_WIN_SIZE];
	assign o_s1_dst_left   = geom_w[S1 + fsctl_pkg::GEOM_DST_POS];
	assign o_s1_dst_top    = geom_h[S1 + fsctl_pkg::GEOM_DST_POS];
	assign o_s1_dst_width  = geom_w[S1 + fsctl_pkg::GEOM_DST_SIZE];
	assign o_s1_dst_height = geom_h[S1 + fsctl_pkg::GEOM_DST_SIZE];

	// --------------------------------------------------
	// readback
	// --------------------------------------------------
	always_comb begin
		rd_word = '0;
		case (i_rd_addr)
			fsctl_pkg::REG_CTRL: begin
				rd_word[1:0] = {o_cfg_hold, o_soft_resetn};
			end
			fsctl_pkg::REG_DST_BMP: begin
				rd_word[BMP_BITS-1:0]      = o_s0_dst_bmp;
				rd_word[STRIDE +: BMP_BITS] = o_s1_dst_bmp;
			end
			fsctl_pkg::REG_INT_EN: begin
				rd_word[0]      = o_int_en[0];
				rd_word[STRIDE] = o_int_en[1];
			end
			fsctl_pkg::REG_INT_STATE: begin
				rd_word[0]      = i_int_state[0];
				rd_word[STRIDE] = i_int_state[1];
			end
			fsctl_pkg::REG_BUF_IDX: begin
				rd_word[BUF_BITS-1:0]      = i_s0_rd_buf_idx;
				rd_word[STRIDE +: BUF_BITS] = i_s1_rd_buf_idx;
			end
			fsctl_pkg::REG_VERSION: begin
				rd_word = `FSCTL_CORE_VERSION;
			end
			default: begin
				if (rd_slot < GEOM_WORDS) begin
					rd_word[WBITS-1:0]      = geom_w[rd_slot[3:0]];
					rd_word[H_LSB +: HBITS] = geom_h[rd_slot[3:0]];
				end
			end
		endcase
	end

	// holds until the next read
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_rd_data <= '0;
		end else if (i_rd_en) begin
			o_rd_data <= rd_word;
		end
	end

endmodule

/* hw/frame_sync_edge.sv */
`timescale 1ns/1ps

module frame_sync_edge (
	input  logic o_clk,
	input  logic o_resetn,
	input  logic i_fsync,
	input  logic i_cfg_hold,
	output logic o_fsync,
	output logic o_update
);

	logic sync_q1;
	logic sync_q2;
	logic sync_q3;
	logic edge_q;

	// two-flop synchroniser, third flop for the edge
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			sync_q1 <= 1'b0;
			sync_q2 <= 1'b0;
			sync_q3 <= 1'b0;
			edge_q  <= 1'b0;
			o_fsync <= 1'b0;
		end else begin
			sync_q1 <= i_fsync;
			sync_q2 <= sync_q1;
			sync_q3 <= sync_q2;
			edge_q  <= sync_q2 & ~sync_q3;
			// new config shows up together with o_fsync
			o_fsync <= edge_q;
		end
	end

	// software holds the shadow copy while it rewrites geometry
	assign o_update = edge_q & ~i_cfg_hold;

endmodule

/* hw/stream_cfg.sv */
`timescale 1ns/1ps

module stream_cfg (
	input  logic                o_clk,
	input  logic                o_resetn,
	input  logic                i_update,
	input  fsctl_pkg::dst_bmp_t i_dst_bmp,
	input  fsctl_pkg::img_w_t   i_width,
	input  fsctl_pkg::img_h_t   i_height,
	input  fsctl_pkg::img_w_t   i_win_left,
	input  fsctl_pkg::img_w_t   i_win_width,
	input  fsctl_pkg::img_h_t   i_win_top,
	input  fsctl_pkg::img_h_t   i_win_height,
	input  fsctl_pkg::img_w_t   i_dst_left,
	input  fsctl_pkg::img_w_t   i_dst_width,
	input  fsctl_pkg::img_h_t   i_dst_top,
	input  fsctl_pkg::img_h_t   i_dst_height,
	output logic                o_soft_resetn,
	output fsctl_pkg::dst_bmp_t o_dst_bmp,
	output fsctl_pkg::img_w_t   o_width,
	output fsctl_pkg::img_h_t   o_height,
	output fsctl_pkg::img_w_t   o_win_left,
	output fsctl_pkg::img_w_t   o_win_width,
	output fsctl_pkg::img_w_t   o_win_righte,
	output fsctl_pkg::img_h_t   o_win_top,
	output fsctl_pkg::img_h_t   o_win_height,
	output fsctl_pkg::img_h_t   o_win_bottome,
	output fsctl_pkg::img_w_t   o_dst_left,
	output fsctl_pkg::img_w_t   o_dst_width,
	output fsctl_pkg::img_w_t   o_dst_righte,
	output fsctl_pkg::img_h_t   o_dst_top,
	output fsctl_pkg::img_h_t   o_dst_height,
	output fsctl_pkg::img_h_t   o_dst_bottome
);

	// --------------------------------------------------
	// active copy, moves only on a frame boundary
	// --------------------------------------------------
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_dst_bmp    <= '0;
			o_width      <= '0;
			o_height     <= '0;
			o_win_left   <= '0;
			o_win_width  <= '0;
			o_win_top    <= '0;
			o_win_height <= '0;
			o_dst_left   <= '0;
			o_dst_width  <= '0;
			o_dst_top    <= '0;
			o_dst_height <= '0;
		end else if (i_update) begin
			o_dst_bmp    <= i_dst_bmp;
			o_width      <= i_width;
			o_height     <= i_height;
			o_win_left   <= i_win_left;
			o_win_width  <= i_win_width;
			o_win_top    <= i_win_top;
			o_win_height <= i_win_height;
			o_dst_left   <= i_dst_left;
			o_dst_width  <= i_dst_width;
			o_dst_top    <= i_dst_top;
			o_dst_height <= i_dst_height;
		end
	end

	// exclusive edges, wrap at field width
	assign o_win_righte  = fsctl_pkg::img_w_t'(o_win_left + o_win_width);
	assign o_win_bottome = fsctl_pkg::img_h_t'(o_win_top + o_win_height);
	assign o_dst_righte  = fsctl_pkg::img_w_t'(o_dst_left + o_dst_width);
	assign o_dst_bottome = fsctl_pkg::img_h_t'(o_dst_top + o_dst_height);

	// stream runs only when it has somewhere to draw
	assign o_soft_resetn = (o_dst_bmp != '0);

endmodule

/* hw/intr_ctrl.sv */
`timescale 1ns/1ps

module intr_ctrl (
	input  logic       o_clk,
	input  logic       o_resetn,
	input  logic [1:0] i_wr_done,
	input  logic [1:0] i_int_en,
	input  logic [1:0] i_int_clr,
	output logic [1:0] o_int_state,
	output logic [1:0] o_rd_en,
	output logic       o_intr
);

	logic [1:0] wr_q;
	logic [1:0] wr_d;
	logic [1:0] rise_q;

	// --------------------------------------------------
	// write-done capture
	// --------------------------------------------------
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			wr_q   <= '0;
			wr_d   <= '0;
			rise_q <= '0;
		end else begin
			wr_q   <= i_wr_done;
			wr_d   <= wr_q;
			rise_q <= wr_q & ~wr_d;
		end
	end

	// sticky state, clear wins over a set in the same cycle
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_int_state <= '0;
			o_rd_en     <= '0;
		end else begin
			o_int_state <= (o_int_state | rise_q) & ~i_int_clr;
			// acknowledged buffer may be read again by the stream
			o_rd_en     <= i_int_clr;
		end
	end

	assign o_intr = |(o_int_state & i_int_en);

endmodule

/* hw/fsctl_top.sv */
`timescale 1ns/1ps

module fsctl_top (
	input  logic                 o_clk,
	input  logic                 o_resetn,
	input  logic                 i_wr_en,
	input  fsctl_pkg::reg_idx_t  i_wr_addr,
	input  fsctl_pkg::reg_data_t i_wr_data,
	input  logic                 i_rd_en,
	input  fsctl_pkg::reg_idx_t  i_rd_addr,
	output fsctl_pkg::reg_data_t o_rd_data,
	input  logic                 i_fsync,
	output logic                 o_fsync,
	output logic                 o_intr,
	output logic                 o_soft_resetn,
	output logic                 o_s0_soft_resetn, o_s1_soft_resetn,
	output fsctl_pkg::dst_bmp_t  o_s0_dst_bmp, o_s1_dst_bmp,
	output fsctl_pkg::img_w_t    o_s0_width, o_s0_win_left, o_s0_win_width, o_s0_win_righte,
	output fsctl_pkg::img_w_t    o_s0_dst_left, o_s0_dst_width, o_s0_dst_righte,
	output fsctl_pkg::img_h_t    o_s0_height, o_s0_win_top, o_s0_win_height, o_s0_win_bottome,
	output fsctl_pkg::img_h_t    o_s0_dst_top, o_s0_dst_height, o_s0_dst_bottome,
	output fsctl_pkg::img_w_t    o_s1_width, o_s1_win_left, o_s1_win_width, o_s1_win_righte,
	output fsctl_pkg::img_w_t    o_s1_dst_left, o_s1_dst_width, o_s1_dst_righte,
	output fsctl_pkg::img_h_t    o_s1_height, o_s1_win_top, o_s1_win_height, o_s1_win_bottome,
	output fsctl_pkg::img_h_t    o_s1_dst_top, o_s1_dst_height, o_s1_dst_bottome,
	input  logic                 i_s0_wr_done, i_s1_wr_done,
	output logic                 o_s0_rd_en, o_s1_rd_en,
	input  fsctl_pkg::buf_idx_t  i_s0_rd_buf_idx, i_s1_rd_buf_idx
);

	logic                cfg_hold;
	logic                update;
	logic [1:0]          int_en;
	logic [1:0]          int_clr;
	logic [1:0]          int_state;
	logic [1:0]          rd_en;
	fsctl_pkg::dst_bmp_t sh_s0_dst_bmp, sh_s1_dst_bmp;
	fsctl_pkg::img_w_t   sh_s0_width, sh_s0_win_left, sh_s0_win_width;
	fsctl_pkg::img_w_t   sh_s0_dst_left, sh_s0_dst_width;
	fsctl_pkg::img_h_t   sh_s0_height, sh_s0_win_top, sh_s0_win_height;
	fsctl_pkg::img_h_t   sh_s0_dst_top, sh_s0_dst_height;
	fsctl_pkg::img_w_t   sh_s1_width, sh_s1_win_left, sh_s1_win_width;
	fsctl_pkg::img_w_t   sh_s1_dst_left, sh_s1_dst_width;
	fsctl_pkg::img_h_t   sh_s1_height, sh_s1_win_top, sh_s1_win_height;
	fsctl_pkg::img_h_t   sh_s1_dst_top, sh_s1_dst_height;

	ctl_regs u_ctl_regs (
		.o_clk(o_clk), .o_resetn(o_resetn),
		.i_wr_en(i_wr_en), .i_wr_addr(i_wr_addr), .i_wr_data(i_wr_data),
		.i_rd_en(i_rd_en), .i_rd_addr(i_rd_addr), .o_rd_data(o_rd_data),
		.i_int_state(int_state),
		.i_s0_rd_buf_idx(i_s0_rd_buf_idx), .i_s1_rd_buf_idx(i_s1_rd_buf_idx),
		.o_soft_resetn(o_soft_resetn), .o_cfg_hold(cfg_hold),
		.o_int_en(int_en), .o_int_clr(int_clr),
		.o_s0_dst_bmp(sh_s0_dst_bmp), .o_s1_dst_bmp(sh_s1_dst_bmp),
		.o_s0_width(sh_s0_width), .o_s0_height(sh_s0_height),
		.o_s0_win_left(sh_s0_win_left), .o_s0_win_top(sh_s0_win_top),
		.o_s0_win_width(sh_s0_win_width), .o_s0_win_height(sh_s0_win_height),
		.o_s0_dst_left(sh_s0_dst_left), .o_s0_dst_top(sh_s0_dst_top),
		.o_s0_dst_width(sh_s0_dst_width), .o_s0_dst_height(sh_s0_dst_height),
		.o_s1_width(sh_s1_width), .o_s1_height(sh_s1_height),
		.o_s1_win_left(sh_s1_win_left), .o_s1_win_top(sh_s1_win_top),
		.o_s1_win_width(sh_s1_win_width), .o_s1_win_height(sh_s1_win_height),
		.o_s1_dst_left(sh_s1_dst_left), .o_s1_dst_top(sh_s1_dst_top),
		.o_s1_dst_width(sh_s1_dst_width), .o_s1_dst_height(sh_s1_dst_height)
	);

	frame_sync_edge u_frame_sync_edge (
		.o_clk(o_clk), .o_resetn(o_resetn),
		.i_fsync(i_fsync), .i_cfg_hold(cfg_hold),
		.o_fsync(o_fsync), .o_update(update)
	);

	// --------------------------------------------------
	// per-stream active configuration
	// --------------------------------------------------
	stream_cfg u_stream0 (
		.o_clk(o_clk), .o_resetn(o_resetn), .i_update(update),
		.i_dst_bmp(sh_s0_dst_bmp),
		.i_width(sh_s0_width), .i_height(sh_s0_height),
		.i_win_left(sh_s0_win_left), .i_win_width(sh_s0_win_width),
		.i_win_top(sh_s0_win_top), .i_win_height(sh_s0_win_height),
		.i_dst_left(sh_s0_dst_left), .i_dst_width(sh_s0_dst_width),
		.i_dst_top(sh_s0_dst_top), .i_dst_height(sh_s0_dst_height),
		.o_soft_resetn(o_s0_soft_resetn), .o_dst_bmp(o_s0_dst_bmp),
		.o_width(o_s0_width), .o_height(o_s0_height),
		.o_win_left(o_s0_win_left), .o_win_width(o_s0_win_width),
		.o_win_righte(o_s0_win_righte), .o_win_top(o_s0_win_top),
		.o_win_height(o_s0_win_height), .o_win_bottome(o_s0_win_bottome),
		.o_dst_left(o_s0_dst_left), .o_dst_width(o_s0_dst_width),
		.o_dst_righte(o_s0_dst_righte), .o_dst_top(o_s0_dst_top),
		.o_dst_height(o_s0_dst_height), .o_dst_bottome(o_s0_dst_bottome)
	);

	stream_cfg u_stream1 (
		.o_clk(o_clk), .o_resetn(o_resetn), .i_update(update),
		.i_dst_bmp(sh_s1_dst_bmp),
		.i_width(sh_s1_width), .i_height(sh_s1_height),
		.i_win_left(sh_s1_win_left), .i_win_width(sh_s1_win_width),
		.i_win_top(sh_s1_win_top), .i_win_height(sh_s1_win_height),
		.i_dst_left(sh_s1_dst_left), .i_dst_width(sh_s1_dst_width),
		.i_dst_top(sh_s1_dst_top), .i_dst_height(sh_s1_dst_height),
		.o_soft_resetn(o_s1_soft_resetn), .o_dst_bmp(o_s1_dst_bmp),
		.o_width(o_s1_width), .o_height(o_s1_height),
		.o_win_left(o_s1_win_left), .o_win_width(o_s1_win_width),
		.o_win_righte(o_s1_win_righte), .o_win_top(o_s1_win_top),
		.o_win_height(o_s1_win_height), .o_win_bottome(o_s1_win_bottome),
		.o_dst_left(o_s1_dst_left), .o_dst_width(o_s1_dst_width),
		.o_dst_righte(o_s1_dst_righte), .o_dst_top(o_s1_dst_top),
		.o_dst_height(o_s1_dst_height), .o_dst_bottome(o_s1_dst_bottome)
	);

	intr_ctrl u_intr_ctrl (
		.o_clk(o_clk), .o_resetn(o_resetn),
		.i_wr_done({i_s1_wr_done, i_s0_wr_done}),
		.i_int_en(int_en), .i_int_clr(int_clr),
		.o_int_state(int_state), .o_rd_en(rd_en), .o_intr(o_intr)
	);

	assign o_s0_rd_en = rd_en[0];
	assign o_s1_rd_en = rd_en[1];

endmodule

/* verification/tb_fsctl.sv */
`timescale 1ns/1ps

module tb_fsctl;

	localparam int          FSYNC_TIMEOUT = 20;
	localparam logic [31:0] GEOM_MASK     = 32'h0FFF_0FFF;

	logic                 o_clk;
	logic                 o_resetn;
	logic                 i_wr_en, i_rd_en, i_fsync;
	fsctl_pkg::reg_idx_t  i_wr_addr, i_rd_addr;
	fsctl_pkg::reg_data_t i_wr_data, o_rd_data;
	logic                 o_fsync, o_intr, o_soft_resetn;
	logic                 o_s0_soft_resetn, o_s1_soft_resetn;
	fsctl_pkg::dst_bmp_t  o_s0_dst_bmp, o_s1_dst_bmp;
	fsctl_pkg::img_w_t    o_s0_width, o_s0_win_left, o_s0_win_width, o_s0_win_righte;
	fsctl_pkg::img_w_t    o_s0_dst_left, o_s0_dst_width, o_s0_dst_righte;
	fsctl_pkg::img_h_t    o_s0_height, o_s0_win_top, o_s0_win_height, o_s0_win_bottome;
	fsctl_pkg::img_h_t    o_s0_dst_top, o_s0_dst_height, o_s0_dst_bottome;
	fsctl_pkg::img_w_t    o_s1_width, o_s1_win_left, o_s1_win_width, o_s1_win_righte;
	fsctl_pkg::img_w_t    o_s1_dst_left, o_s1_dst_width, o_s1_dst_righte;
	fsctl_pkg::img_h_t    o_s1_height, o_s1_win_top, o_s1_win_height, o_s1_win_bottome;
	fsctl_pkg::img_h_t    o_s1_dst_top, o_s1_dst_height, o_s1_dst_bottome;
	logic                 i_s0_wr_done, i_s1_wr_done, o_s0_rd_en, o_s1_rd_en;
	fsctl_pkg::buf_idx_t  i_s0_rd_buf_idx, i_s1_rd_buf_idx;

	// reference model words in readback layout
	logic [31:0] sh_geom [10];
	logic [31:0] act_geom [10];
	logic [31:0] sh_bmp, act_bmp, m_ctrl, m_en;
	logic [1:0]  m_state;

	int errors;
	int tests_ok;
	int tests_bad;
	bit timed_out;

	fsctl_top i_dut (.*);

	always #20 o_clk = ~o_clk;

	// --------------------------------------------------
	// bus access and model helpers
	// --------------------------------------------------
	task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic reg_write(input int addr, input logic [31:0] data);
		@(posedge o_clk);
		i_wr_en   <= 1'b1;
		i_wr_addr <= fsctl_pkg::reg_idx_t'(addr);
		i_wr_data <= data;
		@(posedge o_clk);
		i_wr_en <= 1'b0;
	endtask

	task automatic reg_read(input int addr, output logic [31:0] data);
		@(posedge o_clk);
		i_rd_en   <= 1'b1;
		i_rd_addr <= fsctl_pkg::reg_idx_t'(addr);
		@(posedge o_clk);
		i_rd_en <= 1'b0;
		@(negedge o_clk);
		data = o_rd_data;
	endtask

	function automatic logic [31:0] field_mask(input int addr);
		case (addr)
			0: return 32'h0000_0003;
			1: return 32'h0000_0033;
			2: return 32'h0000_0011;
			default: return GEOM_MASK;
		endcase
	endfunction

	function automatic logic [31:0] model_value(input int addr);
		case (addr)
			0: return m_ctrl;
			1: return sh_bmp;
			2: return m_en;
			default: return sh_geom[addr-5];
		endcase
	endfunction

	// stream 0 bit at 0 and stream 1 bit at 4
	function automatic logic [31:0] pair_word(input logic [1:0] bits);
		return {27'b0, bits[1], 3'b0, bits[0]};
	endfunction

	task automatic write_modeled(input int addr, input logic [31:0] data);
		logic [31:0] v;
		v = data & field_mask(addr);
		reg_write(addr, data);
		case (addr)
			0: m_ctrl = v;
			1: sh_bmp = v;
			2: m_en = v;
			default: sh_geom[addr-5] = v;
		endcase
	endtask

	task automatic randomize_shadow();
		for (int g = 0; g < 10; g++)
			write_modeled(5 + g, $urandom);
		write_modeled(1, $urandom);
	endtask

	// --------------------------------------------------
	// active configuration checks
	// --------------------------------------------------
	function automatic logic [31:0] dut_geom(input int g);
		case (g)
			0: return {4'h0, o_s0_height, 4'h0, o_s0_width};
			1: return {4'h0, o_s0_win_top, 4'h0, o_s0_win_left};
			2: return {4'h0, o_s0_win_height, 4'h0, o_s0_win_width};
			3: return {4'h0, o_s0_dst_top, 4'h0, o_s0_dst_left};
			4: return {4'h0, o_s0_dst_height, 4'h0, o_s0_dst_width};
			5: return {4'h0, o_s1_height, 4'h0, o_s1_width};
			6: return {4'h0, o_s1_win_top, 4'h0, o_s1_win_left};
			7: return {4'h0, o_s1_win_height, 4'h0, o_s1_win_width};
			8: return {4'h0, o_s1_dst_top, 4'h0, o_s1_dst_left};
			default: return {4'h0, o_s1_dst_height, 4'h0, o_s1_dst_width};
		endcase
	endfunction

	function automatic logic [47:0] dut_edges(input int s);
		if (s == 0)
			return {o_s0_win_righte, o_s0_win_bottome, o_s0_dst_righte, o_s0_dst_bottome};
		return {o_s1_win_righte, o_s1_win_bottome, o_s1_dst_righte, o_s1_dst_bottome};
	endfunction

	// edge sums wrap at 12 bits
	function automatic logic [47:0] expected_edges(input int s);
		logic [31:0] win_pos, win_size, dst_pos, dst_size;
		win_pos  = act_geom[s*5 + 1];
		win_size = act_geom[s*5 + 2];
		dst_pos  = act_geom[s*5 + 3];
		dst_size = act_geom[s*5 + 4];
		return {12'(win_pos[11:0] + win_size[11:0]), 12'(win_pos[27:16] + win_size[27:16]),
			12'(dst_pos[11:0] + dst_size[11:0]), 12'(dst_pos[27:16] + dst_size[27:16])};
	endfunction

	task automatic check_active(input string when);
		logic [1:0] exp_rst;
		exp_rst = {act_bmp[5:4] != 2'b00, act_bmp[1:0] != 2'b00};
		for (int g = 0; g < 10; g++)
			check_eq($sformatf("%s, active word %0d", when, g), dut_geom(g), act_geom[g]);
		for (int s = 0; s < 2; s++)
			check_eq($sformatf("%s, stream %0d edges", when, s), dut_edges(s), expected_edges(s));
		check_eq({when, ", dst_bmp"}, {o_s1_dst_bmp, 2'b00, o_s0_dst_bmp}, act_bmp);
		check_eq({when, ", stream soft reset"}, {o_s1_soft_resetn, o_s0_soft_resetn}, exp_rst);
	endtask

	task automatic wait_fsync();
		int n;
		n = 0;
		@(negedge o_clk);
		while (!o_fsync && n < FSYNC_TIMEOUT) begin
			@(negedge o_clk);
			n++;
		end
		if (!o_fsync) begin
			timed_out = 1'b1;
			$display("timeout: no o_fsync pulse within %0d cycles of the fsync edge", FSYNC_TIMEOUT);
		end
	endtask

	task automatic run_frame(input bit expect_update);
		@(posedge o_clk);
		i_fsync <= 1'b1;
		wait_fsync();
		if (!timed_out) begin
			if (expect_update) begin
				act_geom = sh_geom;
				act_bmp  = sh_bmp;
			end
			check_active(expect_update ? "after update" : "while held");
			@(negedge o_clk);
			check_eq("o_fsync one cycle later", o_fsync, 0);
		end
		@(posedge o_clk);
		i_fsync <= 1'b0;
		// let the synchroniser see the low level
		repeat (4) @(posedge o_clk);
	endtask

	task automatic finish_test(input string name, input int start);
		if (errors == start && !timed_out) begin
			tests_ok++;
			$display("test %s: ok", name);
		end else begin
			tests_bad++;
			$display("test %s: FAILED with %0d errors", name, errors - start);
		end
	endtask

	// --------------------------------------------------
	// tests
	// --------------------------------------------------
	task automatic after_reset_values();
		int          start;
		logic [31:0] rd;
		start = errors;
		@(negedge o_clk);
		check_eq("o_fsync", o_fsync, 0);
		check_eq("o_intr", o_intr, 0);
		check_eq("o_soft_resetn", o_soft_resetn, 0);
		check_eq("o_sN_rd_en", {o_s1_rd_en, o_s0_rd_en}, 0);
		check_active("after reset");
		reg_read(fsctl_pkg::REG_VERSION, rd);
		check_eq("version register", rd, 32'hFF00_FF00);
		finish_test("reset values", start);
	endtask

	task automatic register_readback();
		int          start;
		int          sel;
		int          addr;
		logic [31:0] rd;
		start = errors;
		repeat (40) begin
			sel  = $urandom_range(12, 0);
			addr = (sel < 3) ? sel : sel + 2;
			write_modeled(addr, $urandom);
			reg_read(addr, rd);
			check_eq($sformatf("register %0d readback", addr), rd, model_value(addr));
			check_eq("o_soft_resetn", o_soft_resetn, m_ctrl[0]);
		end
		check_active("without fsync edge");
		finish_test("register access", start);
	endtask

	task automatic frame_update();
		int start;
		start = errors;
		write_modeled(0, m_ctrl & 32'h1);
		for (int i = 0; i < 3 && !timed_out; i++) begin
			randomize_shadow();
			run_frame(1'b1);
		end
		finish_test("fsync update", start);
	endtask

	task automatic frame_hold();
		int start;
		start = errors;
		write_modeled(0, m_ctrl | 32'h2);
		randomize_shadow();
		run_frame(1'b0);
		write_modeled(0, m_ctrl & 32'h1);
		// pending shadow goes out on the next frame
		if (!timed_out)
			run_frame(1'b1);
		finish_test("update hold", start);
	endtask

	task automatic interrupt_flow();
		int          start;
		logic [1:0]  pulse;
		logic [1:0]  clr;
		logic [31:0] rd;
		start = errors;
		repeat (8) begin
			write_modeled(2, $urandom);
			pulse = 2'($urandom);
			@(posedge o_clk);
			{i_s1_wr_done, i_s0_wr_done} <= pulse;
			repeat (2) @(posedge o_clk);
			{i_s1_wr_done, i_s0_wr_done} <= 2'b00;
			repeat (3) @(posedge o_clk);
			m_state = m_state | pulse;
			reg_read(fsctl_pkg::REG_INT_STATE, rd);
			check_eq("interrupt state", rd, pair_word(m_state));
			check_eq("o_intr", o_intr, |(m_state & {m_en[4], m_en[0]}));
			clr = 2'($urandom);
			reg_write(fsctl_pkg::REG_INT_STATE, pair_word(clr));
			m_state = m_state & ~clr;
			@(negedge o_clk);
			check_eq("o_sN_rd_en after clear", {o_s1_rd_en, o_s0_rd_en}, clr);
			@(negedge o_clk);
			check_eq("o_sN_rd_en one cycle later", {o_s1_rd_en, o_s0_rd_en}, 0);
			reg_read(fsctl_pkg::REG_INT_STATE, rd);
			check_eq("interrupt state after clear", rd, pair_word(m_state));
		end
		finish_test("interrupts", start);
	endtask

	task automatic buffer_index_readback();
		int          start;
		logic [1:0]  b0;
		logic [1:0]  b1;
		logic [31:0] rd;
		start = errors;
		repeat (6) begin
			b0 = 2'($urandom);
			b1 = 2'($urandom);
			@(posedge o_clk);
			i_s0_rd_buf_idx <= b0;
			i_s1_rd_buf_idx <= b1;
			reg_read(fsctl_pkg::REG_BUF_IDX, rd);
			check_eq("buffer index register", rd, {26'b0, b1, 2'b00, b0});
		end
		finish_test("buffer index", start);
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		void'($urandom(48066));
		o_clk           = 1'b0;
		o_resetn        = 1'b0;
		i_wr_en         = 1'b0;
		i_wr_addr       = '0;
		i_wr_data       = '0;
		i_rd_en         = 1'b0;
		i_rd_addr       = '0;
		i_fsync         = 1'b0;
		i_s0_wr_done    = 1'b0;
		i_s1_wr_done    = 1'b0;
		i_s0_rd_buf_idx = '0;
		i_s1_rd_buf_idx = '0;
		for (int g = 0; g < 10; g++) begin
			sh_geom[g]  = '0;
			act_geom[g] = '0;
		end
		sh_bmp    = '0;
		act_bmp   = '0;
		m_ctrl    = '0;
		m_en      = '0;
		m_state   = '0;
		errors    = 0;
		tests_ok  = 0;
		tests_bad = 0;
		timed_out = 1'b0;

		repeat (10) @(posedge o_clk);
		o_resetn <= 1'b1;

		after_reset_values();
		register_readback();
		frame_update();
		if (!timed_out)
			frame_hold();
		if (!timed_out)
			interrupt_flow();
		if (!timed_out)
			buffer_index_readback();

		$display("tests passed %0d, failed %0d, check errors %0d", tests_ok, tests_bad, errors);
		if (errors == 0 && tests_bad == 0 && !timed_out)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* fsctl.f */
+incdir+hw
hw/fsctl_pkg.sv
hw/ctl_regs.sv
hw/frame_sync_edge.sv
hw/stream_cfg.sv
hw/intr_ctrl.sv
hw/fsctl_top.sv
verification/tb_fsctl.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fsctl testbench with Verilator

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_fsctl -f fsctl.f \
	--Mdir obj_dir -o sim_fsctl > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_fsctl > sim.log 2>&1
cat sim.log

grep -q "^Verification passed$" sim.log && exit 0 || exit 1
